// ==== logic/eth_rx_pkg.sv ====
// Shared widths, Ethernet and FFCP protocol constants, and data types of the receive path
`default_nettype none

package eth_rx_pkg;

	// Basic widths
	localparam int byte_len = 8;
	typedef logic [byte_len-1:0] byte_t;

	// 12-bit colors, four bits per channel
	localparam int color_len = 12;
	typedef logic [color_len-1:0] color_t;

	// One FGP packet fills one 64-color row of video memory
	localparam int fgp_data_len_colors = 64;
	localparam int fgp_data_len_bytes = 96;

	// Video memory write port
	localparam int vram_addr_len = 14;
	typedef logic [vram_addr_len-1:0] vram_addr_t;

	// Ethernet framing
	localparam int eth_preamble_len = 7;
	localparam byte_t eth_preamble_byte = 8'h55;
	localparam byte_t eth_sfd_byte = 8'hd5;
	localparam int eth_mac_len = 6;

	// FFCP ethertype, high byte on the wire first
	localparam logic [2*byte_len-1:0] ffcp_ethertype = 16'h8801;

	// FFCP header fields
	typedef logic [byte_len-1:0] ffcp_type_t;
	typedef logic [byte_len-1:0] ffcp_index_t;

	localparam ffcp_type_t ffcp_type_syn = 8'd0;
	localparam ffcp_type_t ffcp_type_msg = 8'd1;
	localparam ffcp_type_t ffcp_type_ack = 8'd2;

endpackage

`default_nettype wire

// ==== logic/rmii_dibit_assembler.sv ====
// RMII receive front end: dibit-to-byte assembly with frame end and receive error strobes
`timescale 1ns/1ns
`default_nettype none

module rmii_dibit_assembler (
	input  wire                  clk,
	input  wire                  eth_rx_downstream_rst,
	input  wire                  crsdv,
	input  wire [1:0]            rxd,
	input  wire                  rxerr,
	output logic                 byte_valid,
	output eth_rx_pkg::byte_t    byte_data,
	output logic                 frame_end,
	output logic                 rx_abort
);

	logic [1:0]        phase;
	logic              crsdv_q;
	logic              aborted;
	eth_rx_pkg::byte_t shift;

	// Control path
	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			phase <= 2'd0;
			crsdv_q <= 1'b0;
			aborted <= 1'b0;
			byte_valid <= 1'b0;
			frame_end <= 1'b0;
			rx_abort <= 1'b0;
		end else begin
			crsdv_q <= crsdv;
			frame_end <= crsdv_q && !crsdv;
			// Only the first error of a frame is reported
			rx_abort <= crsdv && rxerr && !aborted;
			byte_valid <= crsdv && !rxerr && !aborted && phase == 2'd3;
			if (!crsdv) begin
				phase <= 2'd0;
				aborted <= 1'b0;
			end else if (rxerr) begin
				// Rest of the frame is ignored until carrier drops
				phase <= 2'd0;
				aborted <= 1'b1;
			end else begin
				phase <= phase + 2'd1;
			end
		end
	end

	// Dibits arrive LSB first, so shift in from the top
	always_ff @(posedge clk) begin
		if (crsdv) begin
			shift <= {rxd, shift[7:2]};
			if (phase == 2'd3)
				byte_data <= {rxd, shift[7:2]};
		end
	end

endmodule

`default_nettype wire

// ==== logic/eth_frame_parser.sv ====
// Ethernet header checker: preamble, start delimiter, MAC skip and ethertype match
`timescale 1ns/1ns
`default_nettype none

module eth_frame_parser (
	input  wire                  clk,
	input  wire                  eth_rx_downstream_rst,
	input  wire                  byte_valid,
	input  eth_rx_pkg::byte_t    byte_data,
	input  wire                  frame_end,
	input  wire                  rx_abort,
	output logic                 payload_valid,
	output eth_rx_pkg::byte_t    payload_data,
	output logic                 payload_end,
	output logic                 frame_err
);

	typedef enum logic [2:0] {
		st_preamble,
		st_sfd,
		st_mac,
		st_type_hi,
		st_type_lo,
		st_payload,
		st_drop
	} state_t;

	state_t     state;
	// Counts preamble bytes, then MAC bytes
	logic [3:0] hdr_cnt;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			state <= st_preamble;
			hdr_cnt <= 4'd0;
			payload_valid <= 1'b0;
			payload_end <= 1'b0;
			frame_err <= 1'b0;
		end else begin
			payload_valid <= 1'b0;
			payload_end <= frame_end || rx_abort;
			frame_err <= rx_abort;
			if (frame_end || rx_abort) begin
				state <= st_preamble;
				hdr_cnt <= 4'd0;
			end else if (byte_valid) begin
				case (state)
					st_preamble: begin
						if (byte_data != eth_rx_pkg::eth_preamble_byte) begin
							state <= st_drop;
						end else if (hdr_cnt == 4'(eth_rx_pkg::eth_preamble_len - 1)) begin
							state <= st_sfd;
							hdr_cnt <= 4'd0;
						end else begin
							hdr_cnt <= hdr_cnt + 4'd1;
						end
					end
					st_sfd: begin
						if (byte_data == eth_rx_pkg::eth_sfd_byte)
							state <= st_mac;
						else
							state <= st_drop;
					end
					st_mac: begin
						// Destination and source MAC, not checked
						if (hdr_cnt == 4'(2 * eth_rx_pkg::eth_mac_len - 1)) begin
							state <= st_type_hi;
							hdr_cnt <= 4'd0;
						end else begin
							hdr_cnt <= hdr_cnt + 4'd1;
						end
					end
					st_type_hi: begin
						if (byte_data == eth_rx_pkg::ffcp_ethertype[15:8])
							state <= st_type_lo;
						else
							state <= st_drop;
					end
					st_type_lo: begin
						if (byte_data == eth_rx_pkg::ffcp_ethertype[7:0])
							state <= st_payload;
						else
							state <= st_drop;
					end
					st_payload: begin
						payload_valid <= 1'b1;
					end
					default: begin
						// Drop holds until frame end
						state <= st_drop;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (byte_valid)
			payload_data <= byte_data;
	end

endmodule

`default_nettype wire

// ==== logic/ffcp_fgp_parser.sv ====
// FFCP header and FGP payload parser: type, index, offset and data byte strobes
`timescale 1ns/1ns
`default_nettype none

module ffcp_fgp_parser (
	input  wire                    clk,
	input  wire                    eth_rx_downstream_rst,
	input  wire                    payload_valid,
	input  eth_rx_pkg::byte_t      payload_data,
	input  wire                    payload_end,
	output logic                   meta_valid,
	output eth_rx_pkg::ffcp_type_t  ffcp_type,
	output eth_rx_pkg::ffcp_index_t ffcp_index,
	output logic                   offset_valid,
	output eth_rx_pkg::byte_t      fgp_offset,
	output logic                   data_valid,
	output eth_rx_pkg::byte_t      data_byte,
	output logic                   frame_restart
);

	// 0 type, 1 index, 2 offset, 3 data
	logic [1:0] hdr_pos;
	logic [6:0] data_cnt;
	logic       is_msg;
	logic       type_known;

	assign type_known = ffcp_type == eth_rx_pkg::ffcp_type_syn ||
		ffcp_type == eth_rx_pkg::ffcp_type_msg ||
		ffcp_type == eth_rx_pkg::ffcp_type_ack;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			hdr_pos <= 2'd0;
			data_cnt <= 7'd0;
			is_msg <= 1'b0;
			meta_valid <= 1'b0;
			offset_valid <= 1'b0;
			data_valid <= 1'b0;
			frame_restart <= 1'b0;
		end else begin
			meta_valid <= 1'b0;
			offset_valid <= 1'b0;
			data_valid <= 1'b0;
			frame_restart <= payload_end;
			if (payload_end) begin
				hdr_pos <= 2'd0;
				data_cnt <= 7'd0;
				is_msg <= 1'b0;
			end else if (payload_valid) begin
				case (hdr_pos)
					2'd0: begin
						hdr_pos <= 2'd1;
						is_msg <= payload_data == eth_rx_pkg::ffcp_type_msg;
					end
					2'd1: begin
						hdr_pos <= 2'd2;
						meta_valid <= type_known;
					end
					2'd2: begin
						// SYN and ACK carry no FGP payload
						hdr_pos <= 2'd3;
						offset_valid <= is_msg;
					end
					default: begin
						if (is_msg && data_cnt < 7'(eth_rx_pkg::fgp_data_len_bytes)) begin
							data_valid <= 1'b1;
							data_cnt <= data_cnt + 7'd1;
						end
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (payload_valid) begin
			data_byte <= payload_data;
			case (hdr_pos)
				2'd0: ffcp_type <= payload_data;
				2'd1: ffcp_index <= payload_data;
				2'd2: fgp_offset <= payload_data;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/color_packer.sv ====
// Byte-to-color packer: three data bytes become two 12-bit colors
`timescale 1ns/1ns
`default_nettype none

module color_packer (
	input  wire                  clk,
	input  wire                  eth_rx_downstream_rst,
	input  wire                  frame_restart,
	input  wire                  data_valid,
	input  eth_rx_pkg::byte_t    data_byte,
	output logic                 color_valid,
	output eth_rx_pkg::color_t   color
);

	logic [1:0]        phase;
	eth_rx_pkg::byte_t hold;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			phase <= 2'd0;
			color_valid <= 1'b0;
		end else begin
			color_valid <= 1'b0;
			if (frame_restart) begin
				phase <= 2'd0;
			end else if (data_valid) begin
				color_valid <= phase != 2'd0;
				phase <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
			end
		end
	end

	// b0 b1 b2 -> {b0, b1 high nibble} then {b1 low nibble, b2}
	always_ff @(posedge clk) begin
		if (data_valid) begin
			case (phase)
				2'd0: hold <= data_byte;
				2'd1: begin
					color <= {hold, data_byte[7:4]};
					hold <= data_byte;
				end
				default: color <= {hold[3:0], data_byte};
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/vram_writer.sv ====
// Video memory write port driver: row base from the FGP offset plus a color counter
`timescale 1ns/1ns
`default_nettype none

module vram_writer (
	input  wire                     clk,
	input  wire                     eth_rx_downstream_rst,
	input  wire                     frame_restart,
	input  wire                     offset_valid,
	input  eth_rx_pkg::byte_t       fgp_offset,
	input  wire                     color_valid,
	input  eth_rx_pkg::color_t      color,
	output logic                    vram_we,
	output eth_rx_pkg::vram_addr_t  vram_waddr,
	output eth_rx_pkg::color_t      vram_win
);

	localparam int cnt_len = eth_rx_pkg::vram_addr_len - eth_rx_pkg::byte_len;

	eth_rx_pkg::byte_t  row_base;
	// One extra bit marks a full row
	logic [cnt_len:0]   color_cnt;
	logic               row_open;

	assign row_open = color_cnt < (cnt_len + 1)'(eth_rx_pkg::fgp_data_len_colors);

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			vram_we <= 1'b0;
			color_cnt <= '0;
		end else begin
			vram_we <= 1'b0;
			if (frame_restart || offset_valid) begin
				color_cnt <= '0;
			end else if (color_valid && row_open) begin
				vram_we <= 1'b1;
				color_cnt <= color_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (offset_valid)
			row_base <= fgp_offset;
		if (color_valid) begin
			vram_waddr <= {row_base, color_cnt[cnt_len-1:0]};
			vram_win <= color;
		end
	end

endmodule

`default_nettype wire

// ==== logic/eth_rx_vram.sv ====
// Top level of the Ethernet receive path from RMII pins to the video memory write port
`timescale 1ns/1ns
`default_nettype none

module eth_rx_vram (
	input  wire                     clk,
	input  wire                     eth_rx_downstream_rst,
	input  wire                     crsdv,
	input  wire [1:0]               rxd,
	input  wire                     rxerr,
	output logic                    meta_valid,
	output eth_rx_pkg::ffcp_type_t  ffcp_type,
	output eth_rx_pkg::ffcp_index_t ffcp_index,
	output logic                    frame_err,
	output logic                    vram_we,
	output eth_rx_pkg::vram_addr_t  vram_waddr,
	output eth_rx_pkg::color_t      vram_win
);

	// Assembler to frame parser
	logic              byte_valid;
	eth_rx_pkg::byte_t byte_data;
	logic              frame_end;
	logic              rx_abort;

	// Frame parser to FFCP parser
	logic              payload_valid;
	eth_rx_pkg::byte_t payload_data;
	logic              payload_end;

	// FFCP parser to packer and writer
	logic              offset_valid;
	eth_rx_pkg::byte_t fgp_offset;
	logic              data_valid;
	eth_rx_pkg::byte_t data_byte;
	logic              frame_restart;

	logic               color_valid;
	eth_rx_pkg::color_t color;

	rmii_dibit_assembler i_rmii_dibit_assembler (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.crsdv(crsdv), .rxd(rxd), .rxerr(rxerr),
		.byte_valid(byte_valid), .byte_data(byte_data),
		.frame_end(frame_end), .rx_abort(rx_abort));

	eth_frame_parser i_eth_frame_parser (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.byte_valid(byte_valid), .byte_data(byte_data),
		.frame_end(frame_end), .rx_abort(rx_abort),
		.payload_valid(payload_valid), .payload_data(payload_data),
		.payload_end(payload_end), .frame_err(frame_err));

	ffcp_fgp_parser i_ffcp_fgp_parser (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.payload_valid(payload_valid), .payload_data(payload_data),
		.payload_end(payload_end),
		.meta_valid(meta_valid), .ffcp_type(ffcp_type), .ffcp_index(ffcp_index),
		.offset_valid(offset_valid), .fgp_offset(fgp_offset),
		.data_valid(data_valid), .data_byte(data_byte),
		.frame_restart(frame_restart));

	color_packer i_color_packer (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.frame_restart(frame_restart),
		.data_valid(data_valid), .data_byte(data_byte),
		.color_valid(color_valid), .color(color));

	vram_writer i_vram_writer (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.frame_restart(frame_restart),
		.offset_valid(offset_valid), .fgp_offset(fgp_offset),
		.color_valid(color_valid), .color(color),
		.vram_we(vram_we), .vram_waddr(vram_waddr), .vram_win(vram_win));

endmodule

`default_nettype wire

// ==== include/eth_rx_vram_tb_table.svh ====
// Test frame table for the receive path testbench: stimulus fields and expected results
`ifndef eth_rx_vram_tb_table_svh
`define eth_rx_vram_tb_table_svh

typedef struct packed {
	logic [15:0] ethertype;
	logic [7:0]  ftype;
	logic [7:0]  index;
	logic [7:0]  offset;
	logic [7:0]  data_cnt;
	logic [7:0]  abort_pos;
	logic        bad_preamble;
	logic [7:0]  exp_writes;
	logic        exp_meta;
} frame_row_t;

localparam int n_rows = 10;
localparam logic [7:0] no_abort = 8'hff;

// Fields in order are ethertype, type, index, offset, data bytes, abort at data byte,
// bad preamble, expected writes and expected meta_valid
function automatic frame_row_t table_row(input int i);
	case (i)
		0: table_row = {16'h8801, 8'd1, 8'h11, 8'd0, 8'd96, no_abort, 1'b0, 8'd64, 1'b1};
		1: table_row = {16'h8801, 8'd1, 8'h12, 8'd5, 8'd30, no_abort, 1'b0, 8'd20, 1'b1};
		// Foreign ethertype, then a broken preamble
		2: table_row = {16'h0800, 8'd1, 8'h13, 8'd3, 8'd96, no_abort, 1'b0, 8'd0, 1'b0};
		3: table_row = {16'h8801, 8'd1, 8'h14, 8'd3, 8'd96, no_abort, 1'b1, 8'd0, 1'b0};
		// SYN and ACK
		4: table_row = {16'h8801, 8'd0, 8'h20, 8'd2, 8'd12, no_abort, 1'b0, 8'd0, 1'b1};
		5: table_row = {16'h8801, 8'd2, 8'h21, 8'd0, 8'd0, no_abort, 1'b0, 8'd0, 1'b1};
		// Receive error on data byte 46 leaves 46 whole bytes and 30 colors
		6: table_row = {16'h8801, 8'd1, 8'h30, 8'd7, 8'd96, 8'd46, 1'b0, 8'd30, 1'b1};
		7: table_row = {16'h8801, 8'd1, 8'h31, 8'd9, 8'd96, no_abort, 1'b0, 8'd64, 1'b1};
		// Top row, with bytes beyond one FGP packet
		8: table_row = {16'h8801, 8'd1, 8'h32, 8'd255, 8'd99, no_abort, 1'b0, 8'd64, 1'b1};
		default: table_row = {16'h8801, 8'd1, 8'h33, 8'd1, 8'd32, no_abort, 1'b0, 8'd21, 1'b1};
	endcase
endfunction

`endif

// ==== tests/eth_rx_vram_tb.sv ====
// Testbench for the RMII-to-video-memory receive path: clock, reset, LFSR data, monitor, checks
`timescale 1ns/1ns
`default_nettype none

module eth_rx_vram_tb;

	`include "eth_rx_vram_tb_table.svh"

	// Preamble, SFD, two MACs, ethertype, type, index, offset
	localparam int hdr_len = 25;
	localparam int timeout_cycles = 400;

	logic clk = 1'b0;
	logic eth_rx_downstream_rst;
	logic crsdv;
	logic [1:0] rxd;
	logic rxerr;
	logic meta_valid;
	eth_rx_pkg::ffcp_type_t ffcp_type;
	eth_rx_pkg::ffcp_index_t ffcp_index;
	logic frame_err;
	logic vram_we;
	eth_rx_pkg::vram_addr_t vram_waddr;
	eth_rx_pkg::color_t vram_win;

	logic [31:0] lfsr;
	eth_rx_pkg::byte_t frame_bytes[$];
	eth_rx_pkg::byte_t data_bytes[$];
	eth_rx_pkg::vram_addr_t wr_addr[$];
	eth_rx_pkg::color_t wr_color[$];
	eth_rx_pkg::ffcp_type_t meta_type;
	eth_rx_pkg::ffcp_index_t meta_index;
	int meta_cnt;
	int err_cnt;
	int late_writes;
	int mismatches;
	int tests_failed;

	eth_rx_vram i_eth_rx_vram (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.crsdv(crsdv), .rxd(rxd), .rxerr(rxerr),
		.meta_valid(meta_valid), .ffcp_type(ffcp_type), .ffcp_index(ffcp_index),
		.frame_err(frame_err),
		.vram_we(vram_we), .vram_waddr(vram_waddr), .vram_win(vram_win));

	always #20 clk = ~clk;

	// Records every write, metadata strobe and frame error
	always @(posedge clk) begin
		if (!eth_rx_downstream_rst) begin
			if (vram_we) begin
				wr_addr.push_back(vram_waddr);
				wr_color.push_back(vram_win);
				if (err_cnt != 0)
					late_writes++;
			end
			if (meta_valid) begin
				meta_cnt++;
				meta_type = ffcp_type;
				meta_index = ffcp_index;
			end
			if (frame_err)
				err_cnt++;
		end
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_byte(output eth_rx_pkg::byte_t b);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			b[i] = lfsr[0];
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Fail at %0t ns: %s expected %0h, actual %0h", $time, name, expected, actual);
			mismatches++;
		end
	endtask

	task automatic build_frame(input frame_row_t r);
		eth_rx_pkg::byte_t b;
		frame_bytes.delete();
		data_bytes.delete();
		for (int i = 0; i < eth_rx_pkg::eth_preamble_len; i++)
			frame_bytes.push_back((r.bad_preamble && i == 3) ? 8'h54 : 8'h55);
		frame_bytes.push_back(8'hd5);
		for (int i = 0; i < 2 * eth_rx_pkg::eth_mac_len; i++)
			frame_bytes.push_back(8'ha0 + 8'(i));
		frame_bytes.push_back(r.ethertype[15:8]);
		frame_bytes.push_back(r.ethertype[7:0]);
		frame_bytes.push_back(r.ftype);
		frame_bytes.push_back(r.index);
		frame_bytes.push_back(r.offset);
		for (int i = 0; i < r.data_cnt; i++) begin
			rand_byte(b);
			data_bytes.push_back(b);
			frame_bytes.push_back(b);
		end
	endtask

	// Low dibit first; rxerr marks the first dibit of byte abort_at
	task automatic send_frame(input int abort_at);
		for (int i = 0; i < frame_bytes.size(); i++) begin
			for (int d = 0; d < 4; d++) begin
				@(posedge clk);
				crsdv <= 1'b1;
				rxd <= 2'(frame_bytes[i] >> (2 * d));
				rxerr <= (i == abort_at && d == 0);
			end
		end
		// Two dribble dibits, not a whole byte
		repeat (2) begin
			@(posedge clk);
			rxd <= 2'b00;
			rxerr <= 1'b0;
		end
		@(posedge clk);
		crsdv <= 1'b0;
		repeat (3) @(posedge clk);
	endtask

	task automatic wait_results(input frame_row_t r, output bit timed_out);
		int cycles;
		cycles = 0;
		timed_out = 1'b0;
		while ((wr_addr.size() < r.exp_writes || meta_cnt < r.exp_meta) && !timed_out) begin
			@(negedge clk);
			cycles++;
			timed_out = cycles > timeout_cycles;
		end
		// Room for stray writes well past the pipeline latency
		for (int i = 0; i < 10; i++)
			@(negedge clk);
	endtask

	initial begin
		frame_row_t r;
		bit timed_out;
		int fails_before;
		int g;
		eth_rx_pkg::color_t exp_color;
		eth_rx_pkg::vram_addr_t exp_addr;
		eth_rx_downstream_rst = 1'b1;
		crsdv = 1'b0;
		rxd = 2'b00;
		rxerr = 1'b0;
		lfsr = 32'h31a4_88ce;
		mismatches = 0;
		tests_failed = 0;
		repeat (5) @(posedge clk);
		eth_rx_downstream_rst <= 1'b0;
		for (int t = 0; t < n_rows; t++) begin
			r = table_row(t);
			@(negedge clk);
			wr_addr.delete();
			wr_color.delete();
			meta_cnt = 0;
			err_cnt = 0;
			late_writes = 0;
			fails_before = mismatches;
			build_frame(r);
			send_frame(r.abort_pos == no_abort ? -1 : hdr_len + r.abort_pos);
			wait_results(r, timed_out);
			if (timed_out) begin
				$display("Test %0d: timed out waiting for %0d writes and %0d metadata strobes",
					t, r.exp_writes, r.exp_meta);
				mismatches++;
			end
			check_value("write count", r.exp_writes, wr_addr.size());
			for (int n = 0; n < wr_addr.size() && n < r.exp_writes; n++) begin
				g = 3 * (n / 2);
				if (n % 2 == 0)
					exp_color = {data_bytes[g], data_bytes[g + 1][7:4]};
				else
					exp_color = {data_bytes[g + 1][3:0], data_bytes[g + 2]};
				exp_addr = 14'(r.offset * 64 + n);
				check_value("vram_waddr", exp_addr, wr_addr[n]);
				check_value("vram_win", exp_color, wr_color[n]);
			end
			check_value("meta_valid count", r.exp_meta, meta_cnt);
			if (r.exp_meta) begin
				check_value("ffcp_type", r.ftype, meta_type);
				check_value("ffcp_index", r.index, meta_index);
			end
			check_value("frame_err count", r.abort_pos != no_abort, err_cnt);
			check_value("writes after frame_err", 0, late_writes);
			if (mismatches == fails_before) begin
				$display("Test %0d passed", t);
			end else begin
				$display("Test %0d FAILED", t);
				tests_failed++;
			end
		end
		$display("%0d of %0d tests passed, %0d mismatches",
			n_rows - tests_failed, n_rows, mismatches);
		if (mismatches == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== eth_rx_vram.f ====
+incdir+include
logic/eth_rx_pkg.sv
logic/rmii_dibit_assembler.sv
logic/eth_frame_parser.sv
logic/ffcp_fgp_parser.sv
logic/color_packer.sv
logic/vram_writer.sv
logic/eth_rx_vram.sv
tests/eth_rx_vram_tb.sv
